// File: compile.f
hw/acc_pkg.sv
hw/word_stream_if.sv
hw/ctrl_regs.sv
hw/word_fetch.sv
hw/mac_engine.sv
hw/result_writer.sv
hw/acc_seq.sv
hw/acc_top.sv
bench/acc_tb.sv

// File: run.sh
#!/bin/sh
# build the testbench with Verilator, run it and judge the result from the log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal \
  --top-module acc_tb -f compile.f
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/Vacc_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -qx "Test completed successfully" sim.log; then
  exit 0
fi
exit 1

// File: bench/acc_tb.sv
// testbench for acc_top with memory models under random stalls, register traffic and checks
module acc_tb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int data_w = 64;
  localparam int total_words = 23;
  localparam int watchdog_cycles = total_words * 12 + 200;

  logic                           clk;
  logic                           rst_n;
  logic                           reg_we;
  logic                           reg_re;
  logic [acc_pkg::reg_addr_w-1:0] reg_addr;
  logic [31:0]                    reg_wdata;
  logic [31:0]                    reg_rdata;
  // index 0 is the ifm port, index 1 the weight port
  logic [1:0]                     req_valid;
  logic [1:0]                     req_ready = '0;
  logic [31:0]                    req_addr [2];
  logic [1:0]                     rsp_valid = '0;
  logic [data_w-1:0]              rsp_data [2] = '{default: '0};
  logic                           wr_valid;
  logic                           wr_ready = 1'b0;
  logic [31:0]                    wr_addr;
  logic [31:0]                    wr_data;

  logic [data_w-1:0] ifm_mem [64];
  logic [data_w-1:0] wgt_mem [64];
  logic [31:0]       data_rng = 32'hef386ad9;
  logic [31:0]       mem_rng = 32'hef386ad9;
  int                lat [2] = '{0, 0};
  logic [31:0]       held_addr [2];
  logic [31:0]       exp_base [2];
  int                reads [2] = '{0, 0};
  int                run_words = 0;
  int                writes = 0;
  logic [31:0]       seen_addr;
  logic [31:0]       seen_data;
  logic              hold_wr = 1'b0;
  logic [31:0]       hold_addr;
  logic [31:0]       hold_data;
  string             test_name = "reset";
  int                test_errors = 0;
  int                pass_count = 0;
  int                fail_count = 0;

  acc_top #(.data_w(data_w)) uut (
    .clk(clk), .rst_n(rst_n), .reg_we(reg_we), .reg_re(reg_re), .reg_addr(reg_addr),
    .reg_wdata(reg_wdata), .reg_rdata(reg_rdata),
    .ifm_rd_req_valid(req_valid[0]), .ifm_rd_req_ready(req_ready[0]),
    .ifm_rd_addr(req_addr[0]), .ifm_rd_rsp_valid(rsp_valid[0]),
    .ifm_rd_rsp_data(rsp_data[0]),
    .wgt_rd_req_valid(req_valid[1]), .wgt_rd_req_ready(req_ready[1]),
    .wgt_rd_addr(req_addr[1]), .wgt_rd_rsp_valid(rsp_valid[1]),
    .wgt_rd_rsp_data(rsp_data[1]),
    .wr_valid(wr_valid), .wr_ready(wr_ready), .wr_addr(wr_addr), .wr_data(wr_data)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s ^ (s << 13);
    x = x ^ (x >> 17);
    return x ^ (x << 5);
  endfunction

  function automatic logic [data_w-1:0] random_word();
    logic [63:0] w;
    data_rng = xorshift(data_rng);
    w[31:0] = data_rng;
    data_rng = xorshift(data_rng);
    w[63:32] = data_rng;
    return w;
  endfunction

  // both memories hold 64 words picked by address bits 8:3
  function automatic logic [5:0] word_index(input logic [31:0] base, input int w);
    logic [31:0] a;
    a = base + 32'(8 * w);
    return a[8:3];
  endfunction

  // signed byte lanes multiplied pairwise and summed with 32-bit wrap
  function automatic logic [31:0] dot_ref();
    int  total;
    byte a;
    byte b;
    total = 0;
    for (int w = 0; w < run_words; w++) begin
      for (int k = 0; k < data_w / 8; k++) begin
        a = byte'(ifm_mem[word_index(exp_base[0], w)][8*k +: 8]);
        b = byte'(wgt_mem[word_index(exp_base[1], w)][8*k +: 8]);
        total += a * b;
      end
    end
    return total;
  endfunction

  task automatic check_value(input string what, input logic [31:0] exp, input logic [31:0] act);
    assert (act === exp) else begin
      $display("Fail %s %s: expected %h, actual %h", test_name, what, exp, act);
      test_errors++;
    end
  endtask

  task automatic reg_write(input logic [acc_pkg::reg_addr_w-1:0] a, input logic [31:0] d);
    reg_we <= 1'b1;
    reg_addr <= a;
    reg_wdata <= d;
    @(posedge clk);
    reg_we <= 1'b0;
  endtask

  task automatic reg_read(input logic [acc_pkg::reg_addr_w-1:0] a, output logic [31:0] d);
    reg_re <= 1'b1;
    reg_addr <= a;
    @(posedge clk);
    reg_re <= 1'b0;
    @(posedge clk);
    d = reg_rdata;
  endtask

  task automatic configure(input logic [31:0] ifm_b, input logic [31:0] wgt_b,
                           input logic [31:0] ofm_b, input int n);
    exp_base[0] = ifm_b;
    exp_base[1] = wgt_b;
    run_words = n;
    for (int w = 0; w < n; w++) begin
      ifm_mem[word_index(ifm_b, w)] = random_word();
      wgt_mem[word_index(wgt_b, w)] = random_word();
    end
    reg_write(acc_pkg::REG_IFM_BASE, ifm_b);
    reg_write(acc_pkg::REG_WGT_BASE, wgt_b);
    reg_write(acc_pkg::REG_OFM_BASE, ofm_b);
    reg_write(acc_pkg::REG_WORD_COUNT, 32'(n));
  endtask

  // the extra cycle lets the sequencer clear done before the first poll
  task automatic start_run();
    reads[0] = 0;
    reads[1] = 0;
    writes = 0;
    reg_write(acc_pkg::REG_CTRL, 32'd1);
    @(posedge clk);
  endtask

  task automatic wait_done();
    logic [31:0] rd;
    int          polls;
    rd = '0;
    polls = 0;
    while (!rd[1] && polls < 400) begin
      reg_read(acc_pkg::REG_CTRL, rd);
      polls++;
    end
    assert (rd[1]) else begin
      $display("%s: done never became set", test_name);
      test_errors++;
    end
  endtask

  task automatic check_run(input logic [31:0] ofm_b);
    check_value("writes", 32'd1, 32'(writes));
    check_value("wr_addr", ofm_b, seen_addr);
    check_value("sum", dot_ref(), seen_data);
    check_value("ifm reads", 32'(run_words), 32'(reads[0]));
    check_value("wgt reads", 32'(run_words), 32'(reads[1]));
  endtask

  task automatic finish_test();
    if (test_errors == 0) begin
      $display("test %s: ok", test_name);
      pass_count++;
    end else begin
      $display("test %s: %0d check(s) failed", test_name, test_errors);
      fail_count++;
    end
    test_errors = 0;
  endtask

  // memory models answering 1 to 4 cycles after the request
  always @(posedge clk) begin
    for (int p = 0; p < 2; p++) begin
      rsp_valid[p] <= 1'b0;
      if (lat[p] > 0) begin
        lat[p] = lat[p] - 1;
        if (lat[p] == 0) begin
          rsp_valid[p] <= 1'b1;
          rsp_data[p] <= (p == 0) ? ifm_mem[held_addr[p][8:3]] : wgt_mem[held_addr[p][8:3]];
        end
      end
      if (rst_n && req_valid[p] && req_ready[p]) begin
        held_addr[p] = req_addr[p];
        mem_rng = xorshift(mem_rng);
        lat[p] = 1 + int'(mem_rng[1:0]);
      end
      mem_rng = xorshift(mem_rng);
      req_ready[p] <= rst_n && (mem_rng[1:0] != 2'd0);
    end
    mem_rng = xorshift(mem_rng);
    wr_ready <= rst_n && mem_rng[0];
  end

  // read addresses, read counts and the write handshake
  always @(posedge clk) begin
    if (rst_n) begin
      for (int p = 0; p < 2; p++) begin
        if (req_valid[p] && req_ready[p]) begin
          assert (reads[p] < run_words) else begin
            $display("%s: read request beyond the word count on port %0d", test_name, p);
            test_errors++;
          end
          check_value($sformatf("read address %0d", p), exp_base[p] + 32'(8 * reads[p]),
                      req_addr[p]);
          reads[p]++;
        end
      end
      if (hold_wr) begin
        assert (wr_valid && wr_addr == hold_addr && wr_data == hold_data) else begin
          $display("%s: write dropped or changed before it was accepted", test_name);
          test_errors++;
        end
      end
      if (wr_valid && wr_ready) begin
        writes++;
        seen_addr = wr_addr;
        seen_data = wr_data;
      end
      hold_wr = wr_valid && !wr_ready;
      hold_addr = wr_addr;
      hold_data = wr_data;
    end
  end

  initial begin
    #(watchdog_cycles * 40);
    $display("watchdog expired after %0d cycles, the run hung", watchdog_cycles);
    $display("Test failed");
    $finish;
  end

  initial begin
    logic [31:0] rd;
    rst_n = 1'b0;
    reg_we = 1'b0;
    reg_re = 1'b0;
    reg_addr = '0;
    reg_wdata = '0;
    repeat (3) @(posedge clk);
    rst_n <= 1'b1;
    @(posedge clk);

    reg_read(acc_pkg::REG_CTRL, rd);
    check_value("ctrl", 32'd0, rd);
    repeat (8) begin
      @(negedge clk);
      assert (req_valid == 2'b00 && !wr_valid) else begin
        $display("%s: memory port active before any start", test_name);
        test_errors++;
      end
    end
    @(posedge clk);
    finish_test();

    test_name = "readback";
    reg_write(acc_pkg::REG_IFM_BASE, 32'h1234_5678);
    reg_write(acc_pkg::REG_WGT_BASE, 32'h9abc_def0);
    reg_write(acc_pkg::REG_OFM_BASE, 32'h0f1e_2d3c);
    reg_write(acc_pkg::REG_WORD_COUNT, 32'd5);
    reg_read(acc_pkg::REG_IFM_BASE, rd);
    check_value("ifm_base", 32'h1234_5678, rd);
    reg_read(acc_pkg::REG_WGT_BASE, rd);
    check_value("wgt_base", 32'h9abc_def0, rd);
    reg_read(acc_pkg::REG_OFM_BASE, rd);
    check_value("ofm_base", 32'h0f1e_2d3c, rd);
    reg_read(acc_pkg::REG_WORD_COUNT, rd);
    check_value("word_count", 32'd5, rd);
    finish_test();

    test_name = "single_word";
    configure(32'h0000_0100, 32'h0000_0340, 32'h0000_8000, 1);
    start_run();
    wait_done();
    check_run(32'h0000_8000);
    reg_read(acc_pkg::REG_CTRL, rd);
    check_value("ctrl", 32'd2, rd);
    finish_test();

    test_name = "multi_word";
    configure(32'h0000_0200, 32'h0000_0408, 32'h0000_8010, 7);
    // extreme lanes with the most negative value and minus one
    ifm_mem[word_index(32'h0000_0200, 2)] = 64'h80ff_8001_ff7f_80ff;
    wgt_mem[word_index(32'h0000_0408, 2)] = 64'h8080_ffff_7f80_01ff;
    ifm_mem[word_index(32'h0000_0200, 5)] = {8{8'h80}};
    wgt_mem[word_index(32'h0000_0408, 5)] = {8{8'h80}};
    start_run();
    wait_done();
    check_run(32'h0000_8010);
    finish_test();

    test_name = "back_to_back";
    configure(32'h0000_0048, 32'h0000_0110, 32'h0000_8020, 3);
    start_run();
    wait_done();
    check_run(32'h0000_8020);
    configure(32'h0000_0080, 32'h0000_0180, 32'h0000_8030, 5);
    start_run();
    reg_read(acc_pkg::REG_CTRL, rd);
    check_value("ctrl after start", 32'd1, rd);
    wait_done();
    check_run(32'h0000_8030);
    finish_test();

    test_name = "start_while_busy";
    configure(32'h0000_00c0, 32'h0000_01c0, 32'h0000_8040, 7);
    start_run();
    repeat (6) @(posedge clk);
    reg_write(acc_pkg::REG_CTRL, 32'd1);
    wait_done();
    repeat (10) @(posedge clk);
    check_run(32'h0000_8040);
    finish_test();

    $display("tests passed: %0d, tests failed: %0d", pass_count, fail_count);
    if (fail_count == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// File: hw/acc_top.sv
// dot-product accelerator top that exposes the register port and plain memory ports
module acc_top #(
  parameter int data_w = 64
) (
  input  logic                           clk,
  input  logic                           rst_n,
  input  logic                           reg_we,
  input  logic                           reg_re,
  input  logic [acc_pkg::reg_addr_w-1:0] reg_addr,
  input  logic [31:0]                    reg_wdata,
  output logic [31:0]                    reg_rdata,
  output logic                           ifm_rd_req_valid,
  input  logic                           ifm_rd_req_ready,
  output logic [acc_pkg::addr_w-1:0]     ifm_rd_addr,
  input  logic                           ifm_rd_rsp_valid,
  input  logic [data_w-1:0]              ifm_rd_rsp_data,
  output logic                           wgt_rd_req_valid,
  input  logic                           wgt_rd_req_ready,
  output logic [acc_pkg::addr_w-1:0]     wgt_rd_addr,
  input  logic                           wgt_rd_rsp_valid,
  input  logic [data_w-1:0]              wgt_rd_rsp_data,
  output logic                           wr_valid,
  input  logic                           wr_ready,
  output logic [acc_pkg::addr_w-1:0]     wr_addr,
  output logic [acc_pkg::acc_w-1:0]      wr_data
);

  logic                       start;
  logic                       launch;
  logic                       busy;
  logic                       done;
  logic [acc_pkg::addr_w-1:0] ifm_base;
  logic [acc_pkg::addr_w-1:0] wgt_base;
  logic [acc_pkg::addr_w-1:0] ofm_base;
  logic [31:0]                word_count;
  logic                       sum_valid;
  logic                       sum_ready;
  logic                       sum_fire;
  logic [acc_pkg::acc_w-1:0]  sum;
  logic                       write_done;

  assign sum_fire = sum_valid && sum_ready;

  word_stream_if #(.data_w(data_w)) ifm_s ();
  word_stream_if #(.data_w(data_w)) wgt_s ();

  ctrl_regs u_ctrl_regs (
    .clk(clk), .rst_n(rst_n),
    .reg_we(reg_we), .reg_re(reg_re), .reg_addr(reg_addr),
    .reg_wdata(reg_wdata), .reg_rdata(reg_rdata),
    .busy(busy), .done(done), .start(start),
    .ifm_base(ifm_base), .wgt_base(wgt_base), .ofm_base(ofm_base),
    .word_count(word_count)
  );

  acc_seq u_acc_seq (
    .clk(clk), .rst_n(rst_n), .start(start), .sum_fire(sum_fire),
    .write_done(write_done), .launch(launch), .busy(busy), .done(done)
  );

  word_fetch #(.data_w(data_w)) u_ifm_fetch (
    .clk(clk), .rst_n(rst_n), .launch(launch),
    .base(ifm_base), .word_count(word_count),
    .rd_req_valid(ifm_rd_req_valid), .rd_req_ready(ifm_rd_req_ready),
    .rd_addr(ifm_rd_addr), .rd_rsp_valid(ifm_rd_rsp_valid),
    .rd_rsp_data(ifm_rd_rsp_data), .out(ifm_s.src)
  );

  word_fetch #(.data_w(data_w)) u_wgt_fetch (
    .clk(clk), .rst_n(rst_n), .launch(launch),
    .base(wgt_base), .word_count(word_count),
    .rd_req_valid(wgt_rd_req_valid), .rd_req_ready(wgt_rd_req_ready),
    .rd_addr(wgt_rd_addr), .rd_rsp_valid(wgt_rd_rsp_valid),
    .rd_rsp_data(wgt_rd_rsp_data), .out(wgt_s.src)
  );

  mac_engine #(.data_w(data_w)) u_mac_engine (
    .clk(clk), .rst_n(rst_n), .launch(launch),
    .ifm_in(ifm_s.snk), .wgt_in(wgt_s.snk),
    .sum_valid(sum_valid), .sum_ready(sum_ready), .sum(sum)
  );

  result_writer u_result_writer (
    .clk(clk), .rst_n(rst_n), .ofm_base(ofm_base),
    .sum_valid(sum_valid), .sum_ready(sum_ready), .sum(sum),
    .wr_valid(wr_valid), .wr_ready(wr_ready), .wr_addr(wr_addr),
    .wr_data(wr_data), .write_done(write_done)
  );

endmodule

// File: hw/acc_seq.sv
// run sequencer that launches the fetch units and engine and tracks busy and sticky done
module acc_seq (
  input  logic clk,
  input  logic rst_n,
  input  logic start,
  input  logic sum_fire,
  input  logic write_done,
  output logic launch,
  output logic busy,
  output logic done
);

  acc_pkg::seq_state_e state;

  assign busy = state != acc_pkg::SEQ_IDLE;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state  <= acc_pkg::SEQ_IDLE;
      launch <= 1'b0;
      done   <= 1'b0;
    end else begin
      launch <= 1'b0;
      case (state)
        acc_pkg::SEQ_IDLE: begin
          // a start while busy is dropped
          if (start) begin
            state  <= acc_pkg::SEQ_RUN;
            launch <= 1'b1;
            done   <= 1'b0;
          end
        end
        acc_pkg::SEQ_RUN: begin
          if (sum_fire) begin
            state <= acc_pkg::SEQ_WRITE;
          end
        end
        acc_pkg::SEQ_WRITE: begin
          if (write_done) begin
            state <= acc_pkg::SEQ_IDLE;
            done  <= 1'b1;
          end
        end
        default: state <= acc_pkg::SEQ_IDLE;
      endcase
    end
  end

endmodule

// File: hw/result_writer.sv
// holds the finished sum and drives the single write until memory takes it
module result_writer (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic [acc_pkg::addr_w-1:0] ofm_base,
  input  logic                       sum_valid,
  output logic                       sum_ready,
  input  logic [acc_pkg::acc_w-1:0]  sum,
  output logic                       wr_valid,
  input  logic                       wr_ready,
  output logic [acc_pkg::addr_w-1:0] wr_addr,
  output logic [acc_pkg::acc_w-1:0]  wr_data,
  output logic                       write_done
);

  assign sum_ready = !wr_valid;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_valid   <= 1'b0;
      write_done <= 1'b0;
    end else begin
      write_done <= wr_valid && wr_ready;
      if (sum_valid && sum_ready) begin
        wr_valid <= 1'b1;
      end else if (wr_ready) begin
        wr_valid <= 1'b0;
      end
    end
  end

  // payload only moves when a new sum is taken
  always_ff @(posedge clk) begin
    if (sum_valid && sum_ready) begin
      wr_addr <= ofm_base;
      wr_data <= sum;
    end
  end

endmodule

// File: hw/mac_engine.sv
// pairs ifm and weight words, multiplies the signed byte lanes and accumulates the sum
module mac_engine #(
  parameter int data_w = 64
) (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      launch,
  word_stream_if.snk                ifm_in,
  word_stream_if.snk                wgt_in,
  output logic                      sum_valid,
  input  logic                      sum_ready,
  output logic [acc_pkg::acc_w-1:0] sum
);

  localparam int lanes = data_w / 8;

  logic                      take;
  logic [acc_pkg::acc_w-1:0] lane_sum;

  // both streams advance together and are held off while the sum waits
  assign take         = ifm_in.valid && wgt_in.valid && !sum_valid;
  assign ifm_in.ready = take;
  assign wgt_in.ready = take;

  always_comb begin
    logic signed [7:0]  a;
    logic signed [7:0]  b;
    logic signed [15:0] p;
    lane_sum = '0;
    for (int k = 0; k < lanes; k++) begin
      a = ifm_in.data[8*k +: 8];
      b = wgt_in.data[8*k +: 8];
      p = a * b;
      lane_sum = lane_sum + {{(acc_pkg::acc_w-16){p[15]}}, p};
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      sum       <= '0;
      sum_valid <= 1'b0;
    end else begin
      if (launch) begin
        sum <= '0;
      end else if (take) begin
        sum <= sum + lane_sum;
        if (ifm_in.last) begin
          sum_valid <= 1'b1;
        end
      end
      if (sum_valid && sum_ready) begin
        sum_valid <= 1'b0;
      end
    end
  end

endmodule

// File: hw/word_fetch.sv
// walks one vector in memory with a single outstanding read and streams the words out
module word_fetch #(
  parameter int data_w = 64
) (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       launch,
  input  logic [acc_pkg::addr_w-1:0] base,
  input  logic [31:0]                word_count,
  output logic                       rd_req_valid,
  input  logic                       rd_req_ready,
  output logic [acc_pkg::addr_w-1:0] rd_addr,
  input  logic                       rd_rsp_valid,
  input  logic [data_w-1:0]          rd_rsp_data,
  word_stream_if.src                 out
);

  localparam int lanes = data_w / 8;

  logic [31:0] remaining;
  // request accepted, response not yet back
  logic        pending;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rd_req_valid <= 1'b0;
      rd_addr      <= '0;
      remaining    <= '0;
      pending      <= 1'b0;
      out.valid    <= 1'b0;
      out.last     <= 1'b0;
    end else begin
      if (launch) begin
        rd_addr      <= base;
        remaining    <= word_count;
        rd_req_valid <= 1'b1;
      end else if (rd_req_valid && rd_req_ready) begin
        rd_req_valid <= 1'b0;
        pending      <= 1'b1;
        rd_addr      <= rd_addr + acc_pkg::addr_w'(lanes);
      end
      if (pending && rd_rsp_valid) begin
        pending   <= 1'b0;
        out.valid <= 1'b1;
        // a zero count is run as a single word
        out.last  <= remaining <= 32'd1;
        remaining <= remaining - 32'd1;
      end
      if (out.valid && out.ready) begin
        out.valid <= 1'b0;
        if (!out.last) begin
          rd_req_valid <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (pending && rd_rsp_valid) begin
      out.data <= rd_rsp_data;
    end
  end

endmodule

// File: hw/ctrl_regs.sv
// host-facing configuration and status registers that turn a ctrl write into a start pulse
module ctrl_regs (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          reg_we,
  input  logic                          reg_re,
  input  logic [acc_pkg::reg_addr_w-1:0] reg_addr,
  input  logic [31:0]                   reg_wdata,
  output logic [31:0]                   reg_rdata,
  input  logic                          busy,
  input  logic                          done,
  output logic                          start,
  output logic [acc_pkg::addr_w-1:0]    ifm_base,
  output logic [acc_pkg::addr_w-1:0]    wgt_base,
  output logic [acc_pkg::addr_w-1:0]    ofm_base,
  output logic [31:0]                   word_count
);

  acc_pkg::reg_addr_e addr;

  assign addr = acc_pkg::reg_addr_e'(reg_addr);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      start      <= 1'b0;
      ifm_base   <= '0;
      wgt_base   <= '0;
      ofm_base   <= '0;
      word_count <= '0;
      reg_rdata  <= '0;
    end else begin
      start <= 1'b0;
      if (reg_we) begin
        case (addr)
          acc_pkg::REG_CTRL:       start <= reg_wdata[0];
          acc_pkg::REG_IFM_BASE:   ifm_base <= reg_wdata;
          acc_pkg::REG_WGT_BASE:   wgt_base <= reg_wdata;
          acc_pkg::REG_OFM_BASE:   ofm_base <= reg_wdata;
          acc_pkg::REG_WORD_COUNT: word_count <= reg_wdata;
          default: ;
        endcase
      end
      // read data lands one cycle after reg_re
      if (reg_re) begin
        case (addr)
          acc_pkg::REG_CTRL:       reg_rdata <= {30'd0, done, busy};
          acc_pkg::REG_IFM_BASE:   reg_rdata <= ifm_base;
          acc_pkg::REG_WGT_BASE:   reg_rdata <= wgt_base;
          acc_pkg::REG_OFM_BASE:   reg_rdata <= ofm_base;
          acc_pkg::REG_WORD_COUNT: reg_rdata <= word_count;
          default:                 reg_rdata <= '0;
        endcase
      end
    end
  end

endmodule

// File: hw/word_stream_if.sv
// valid/ready word stream from a fetch unit into the MAC engine
interface word_stream_if #(
  parameter int data_w = 64
) ();

  logic              valid;
  logic              ready;
  logic [data_w-1:0] data;
  // final word of the vector
  logic              last;

  modport src (output valid, output data, output last, input ready);

  modport snk (input valid, input data, input last, output ready);

endinterface

// File: hw/acc_pkg.sv
// shared widths, register map and sequencer states for the dot-product accelerator
package acc_pkg;

  // byte address width on the memory ports
  localparam int addr_w = 32;

  // accumulator and result word
  localparam int acc_w = 32;

  // host register port
  localparam int reg_addr_w = 3;

  // register map seen by the host
  typedef enum logic [reg_addr_w-1:0] {
    REG_CTRL       = 3'd0,
    REG_IFM_BASE   = 3'd1,
    REG_WGT_BASE   = 3'd2,
    REG_OFM_BASE   = 3'd3,
    REG_WORD_COUNT = 3'd4
  } reg_addr_e;

  // run sequencer
  typedef enum logic [1:0] {
    SEQ_IDLE  = 2'd0,
    SEQ_RUN   = 2'd1,
    SEQ_WRITE = 2'd2
  } seq_state_e;

endpackage
